// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -f turf_ctrl.f --top-module turf_ctrl_tb -o turf_ctrl_sim
	@out="$$(./obj_dir/turf_ctrl_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

// ==== rtl/turf_apb_decode.sv ====
`timescale 1ns/10ps
module turf_apb_decode (
    input  logic                                ps_clk,
    input  logic                                rst_i,
    // APB slave
    input  logic                                psel_i,
    input  logic                                penable_i,
    input  logic                                pwrite_i,
    input  turf_pkg::addr_t                     paddr_i,
    input  turf_pkg::data_t                     pwdata_i,
    output turf_pkg::data_t                     prdata_o,
    output logic                                pready_o,
    output logic                                pslverr_o,
    // Local registers
    output logic                                reg_wr_o,
    output logic [turf_pkg::REG_OFFSET_W-1:0]   reg_offset_o,
    output turf_pkg::data_t                     reg_wdata_o,
    input  turf_pkg::data_t                     reg_rdata_i,
    // Crate bridge
    output logic                                breq_valid_o,
    output logic                                breq_write_o,
    output turf_pkg::crate_addr_t               breq_addr_o,
    output turf_pkg::data_t                     breq_wdata_o,
    input  logic                                bdone_i,
    input  turf_pkg::data_t                     brdata_i,
    input  logic                                berr_i
);

    logic access;
    logic is_crate;
    logic in_window;
    logic req_sent_q;

    assign access   = psel_i && penable_i;
    // Top address bit selects crate space
    assign is_crate = paddr_i[turf_pkg::ADDR_W-1];
    // Local registers only answer in the lowest 16 bytes
    assign in_window =
        paddr_i[turf_pkg::CRATE_ADDR_W-1:turf_pkg::REG_OFFSET_W] == '0;

    // Local side
    assign reg_wr_o     = access && pwrite_i && !is_crate && in_window;
    assign reg_offset_o = paddr_i[turf_pkg::REG_OFFSET_W-1:0];
    assign reg_wdata_o  = pwdata_i;

    // One request per crate transfer, in its first access cycle
    assign breq_valid_o = access && is_crate && !req_sent_q;
    assign breq_write_o = pwrite_i;
    assign breq_addr_o  = paddr_i[turf_pkg::CRATE_ADDR_W-1:0];
    assign breq_wdata_o = pwdata_i;

    always_ff @(posedge ps_clk) begin
        if (rst_i) begin
            req_sent_q <= 1'b0;
        end else if (bdone_i) begin
            req_sent_q <= 1'b0;
        end else if (breq_valid_o) begin
            req_sent_q <= 1'b1;
        end
    end

    // Completion back to the requester
    assign pready_o  = access && (!is_crate || bdone_i);
    assign pslverr_o = access && is_crate && bdone_i && berr_i;
    assign prdata_o  = is_crate  ? brdata_i    :
                       in_window ? reg_rdata_i : '0;

endmodule

// ==== rtl/turf_crate_bridge.sv ====
`timescale 1ns/10ps
module turf_crate_bridge (
    input  logic                    ps_clk,
    input  logic                    rst_i,
    // Request from the APB decode
    input  logic                    breq_valid_i,
    input  logic                    breq_write_i,
    input  turf_pkg::crate_addr_t   breq_addr_i,
    input  turf_pkg::data_t         breq_wdata_i,
    output logic                    bdone_o,
    output turf_pkg::data_t         brdata_o,
    output logic                    berr_o,
    // Bridge control and link state
    input  logic                    bridge_en_i,
    input  turf_pkg::link_sel_t     bridge_link_i,
    input  turf_pkg::link_mask_t    link_up_i,
    // Command stream
    output logic                    cmd_valid_o,
    output turf_pkg::crate_cmd_t    cmd_data_o,
    input  logic                    cmd_ready_i,
    // Response stream
    input  logic                    resp_valid_i,
    input  turf_pkg::crate_resp_t   resp_data_i,
    output logic                    resp_ready_o,
    // Error events toward the status register
    output logic                    timeout_pulse_o,
    output logic                    invalid_pulse_o,
    output turf_pkg::link_sel_t     flag_link_o
);

    typedef enum logic [1:0] {ST_IDLE, ST_ISSUE, ST_WAIT} state_t;

    state_t                           state_q;
    turf_pkg::crate_cmd_t             cmd_q;
    logic [turf_pkg::TIMEOUT_W-1:0]   timer_q;
    logic                             link_ok;
    logic                             timer_done;
    logic                             resp_hit;

    assign link_ok    = bridge_en_i && link_up_i[bridge_link_i];
    assign timer_done = timer_q == turf_pkg::TIMEOUT_LAST;
    assign resp_hit   = (state_q == ST_WAIT) && resp_valid_i;

    assign cmd_valid_o  = state_q == ST_ISSUE;
    assign cmd_data_o   = cmd_q;
    // Stray responses are drained while idle
    assign resp_ready_o = state_q != ST_ISSUE;
    assign flag_link_o  = cmd_q.link;

    always_ff @(posedge ps_clk) begin
        if (rst_i) begin
            state_q         <= ST_IDLE;
            timer_q         <= '0;
            bdone_o         <= 1'b0;
            berr_o          <= 1'b0;
            timeout_pulse_o <= 1'b0;
            invalid_pulse_o <= 1'b0;
        end else begin
            bdone_o         <= 1'b0;
            timeout_pulse_o <= 1'b0;
            invalid_pulse_o <= 1'b0;
            // Counter saturates, it runs through issue and wait
            if (state_q != ST_IDLE && !timer_done) begin
                timer_q <= timer_q + 1'b1;
            end
            case (state_q)
                ST_IDLE: begin
                    if (breq_valid_i) begin
                        timer_q <= '0;
                        if (link_ok) begin
                            state_q <= ST_ISSUE;
                        end else begin
                            bdone_o         <= 1'b1;
                            berr_o          <= 1'b1;
                            invalid_pulse_o <= 1'b1;
                        end
                    end
                end
                ST_ISSUE: begin
                    if (cmd_ready_i) begin
                        state_q <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (resp_valid_i) begin
                        bdone_o <= 1'b1;
                        berr_o  <= resp_data_i.err;
                        state_q <= ST_IDLE;
                    end else if (timer_done) begin
                        bdone_o         <= 1'b1;
                        berr_o          <= 1'b1;
                        timeout_pulse_o <= 1'b1;
                        state_q         <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Command capture and returned data
    always_ff @(posedge ps_clk) begin
        if (state_q == ST_IDLE && breq_valid_i) begin
            cmd_q.link  <= bridge_link_i;
            cmd_q.write <= breq_write_i;
            cmd_q.addr  <= breq_addr_i;
            cmd_q.wdata <= breq_wdata_i;
        end
        brdata_o <= resp_hit ? resp_data_i.rdata : turf_pkg::BRIDGE_ERR_DATA;
    end

endmodule

// ==== rtl/turf_ctrl_top.sv ====
`timescale 1ns/10ps
module turf_ctrl_top (
    input  logic                    ps_clk,
    input  logic                    rst_i,
    // APB
    input  logic                    psel_i,
    input  logic                    penable_i,
    input  logic                    pwrite_i,
    input  turf_pkg::addr_t         paddr_i,
    input  turf_pkg::data_t         pwdata_i,
    output turf_pkg::data_t         prdata_o,
    output logic                    pready_o,
    output logic                    pslverr_o,
    // TURFIO links
    input  turf_pkg::link_mask_t    link_up_i,
    output logic                    cmd_valid_o,
    input  logic                    cmd_ready_i,
    output turf_pkg::crate_cmd_t    cmd_data_o,
    input  logic                    resp_valid_i,
    output logic                    resp_ready_o,
    input  turf_pkg::crate_resp_t   resp_data_i
);

    //////////////////////////////////////////////////////////////////////
    // Internal nets
    //////////////////////////////////////////////////////////////////////

    logic                                reg_wr;
    logic [turf_pkg::REG_OFFSET_W-1:0]   reg_offset;
    turf_pkg::data_t                     reg_wdata;
    turf_pkg::data_t                     reg_rdata;
    logic                                breq_valid;
    logic                                breq_write;
    turf_pkg::crate_addr_t               breq_addr;
    turf_pkg::data_t                     breq_wdata;
    logic                                bdone;
    turf_pkg::data_t                     brdata;
    logic                                berr;
    logic                                bridge_en;
    turf_pkg::link_sel_t                 bridge_link;
    logic                                timeout_pulse;
    logic                                invalid_pulse;
    turf_pkg::link_sel_t                 flag_link;
    // Bridge side of the two slices
    logic                                bcmd_valid;
    logic                                bcmd_ready;
    turf_pkg::crate_cmd_t                bcmd_data;
    logic                                bresp_valid;
    logic                                bresp_ready;
    turf_pkg::crate_resp_t               bresp_data;

    //////////////////////////////////////////////////////////////////////
    // Instances
    //////////////////////////////////////////////////////////////////////

    turf_apb_decode u_decode (
        .ps_clk(ps_clk), .rst_i(rst_i),
        .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
        .paddr_i(paddr_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
        .pready_o(pready_o), .pslverr_o(pslverr_o),
        .reg_wr_o(reg_wr), .reg_offset_o(reg_offset),
        .reg_wdata_o(reg_wdata), .reg_rdata_i(reg_rdata),
        .breq_valid_o(breq_valid), .breq_write_o(breq_write),
        .breq_addr_o(breq_addr), .breq_wdata_o(breq_wdata),
        .bdone_i(bdone), .brdata_i(brdata), .berr_i(berr)
    );

    turf_id_regs u_id_regs (
        .ps_clk(ps_clk), .rst_i(rst_i),
        .reg_wr_i(reg_wr), .reg_offset_i(reg_offset),
        .reg_wdata_i(reg_wdata), .reg_rdata_o(reg_rdata),
        .link_up_i(link_up_i), .timeout_pulse_i(timeout_pulse),
        .invalid_pulse_i(invalid_pulse), .flag_link_i(flag_link),
        .bridge_en_o(bridge_en), .bridge_link_o(bridge_link)
    );

    turf_crate_bridge u_bridge (
        .ps_clk(ps_clk), .rst_i(rst_i),
        .breq_valid_i(breq_valid), .breq_write_i(breq_write),
        .breq_addr_i(breq_addr), .breq_wdata_i(breq_wdata),
        .bdone_o(bdone), .brdata_o(brdata), .berr_o(berr),
        .bridge_en_i(bridge_en), .bridge_link_i(bridge_link),
        .link_up_i(link_up_i),
        .cmd_valid_o(bcmd_valid), .cmd_data_o(bcmd_data), .cmd_ready_i(bcmd_ready),
        .resp_valid_i(bresp_valid), .resp_data_i(bresp_data),
        .resp_ready_o(bresp_ready),
        .timeout_pulse_o(timeout_pulse), .invalid_pulse_o(invalid_pulse),
        .flag_link_o(flag_link)
    );

    turf_stream_slice #(.payload_t(turf_pkg::crate_cmd_t)) u_cmd_slice (
        .ps_clk(ps_clk), .rst_i(rst_i),
        .s_valid_i(bcmd_valid), .s_ready_o(bcmd_ready), .s_data_i(bcmd_data),
        .m_valid_o(cmd_valid_o), .m_ready_i(cmd_ready_i), .m_data_o(cmd_data_o)
    );

    turf_stream_slice #(.payload_t(turf_pkg::crate_resp_t)) u_resp_slice (
        .ps_clk(ps_clk), .rst_i(rst_i),
        .s_valid_i(resp_valid_i), .s_ready_o(resp_ready_o), .s_data_i(resp_data_i),
        .m_valid_o(bresp_valid), .m_ready_i(bresp_ready), .m_data_o(bresp_data)
    );

endmodule

// ==== rtl/turf_id_regs.sv ====
`timescale 1ns/10ps
module turf_id_regs (
    input  logic                                ps_clk,
    input  logic                                rst_i,
    input  logic                                reg_wr_i,
    input  logic [turf_pkg::REG_OFFSET_W-1:0]   reg_offset_i,
    input  turf_pkg::data_t                     reg_wdata_i,
    output turf_pkg::data_t                     reg_rdata_o,
    // Link status and error events
    input  turf_pkg::link_mask_t                link_up_i,
    input  logic                                timeout_pulse_i,
    input  logic                                invalid_pulse_i,
    input  turf_pkg::link_sel_t                 flag_link_i,
    // Bridge control
    output logic                                bridge_en_o,
    output turf_pkg::link_sel_t                 bridge_link_o
);

    localparam int NL = turf_pkg::NUM_LINKS;

    logic                 bridge_en_q;
    turf_pkg::link_sel_t  bridge_link_q;
    turf_pkg::link_mask_t timeout_q;
    turf_pkg::link_mask_t invalid_q;
    turf_pkg::link_mask_t flag_mask;
    logic                 stat_wr;
    turf_pkg::data_t      ctrl_word;

    assign stat_wr = reg_wr_i && (reg_offset_i == turf_pkg::REG_BRIDGE_STAT);

    always_comb begin
        flag_mask = '0;
        flag_mask[flag_link_i] = 1'b1;
    end

    always_ff @(posedge ps_clk) begin
        if (rst_i) begin
            bridge_en_q   <= 1'b0;
            bridge_link_q <= '0;
            timeout_q     <= '0;
            invalid_q     <= '0;
        end else begin
            if (reg_wr_i && (reg_offset_i == turf_pkg::REG_BRIDGE_CTRL)) begin
                bridge_en_q   <= reg_wdata_i[turf_pkg::BRIDGE_EN_BIT];
                bridge_link_q <= reg_wdata_i[turf_pkg::LINK_W-1:0];
            end
            // Write one clears, a new event in the same cycle wins
            timeout_q <= (timeout_q & ~(stat_wr ? reg_wdata_i[NL-1:0] : '0))
                       | (timeout_pulse_i ? flag_mask : '0);
            invalid_q <= (invalid_q & ~(stat_wr ? reg_wdata_i[2*NL-1:NL] : '0))
                       | (invalid_pulse_i ? flag_mask : '0);
        end
    end

    always_comb begin
        ctrl_word = '0;
        ctrl_word[turf_pkg::BRIDGE_EN_BIT] = bridge_en_q;
        ctrl_word[turf_pkg::LINK_W-1:0] = bridge_link_q;
    end

    always_comb begin
        case (reg_offset_i)
            turf_pkg::REG_IDENT:       reg_rdata_o = turf_pkg::IDENT;
            turf_pkg::REG_DATEVERSION: reg_rdata_o = turf_pkg::DATEVERSION;
            turf_pkg::REG_BRIDGE_CTRL: reg_rdata_o = ctrl_word;
            turf_pkg::REG_BRIDGE_STAT:
                reg_rdata_o = {{(turf_pkg::DATA_W-3*NL){1'b0}},
                               link_up_i, invalid_q, timeout_q};
            default:                   reg_rdata_o = '0;
        endcase
    end

    assign bridge_en_o   = bridge_en_q;
    assign bridge_link_o = bridge_link_q;

endmodule

// ==== rtl/turf_pkg.sv ====
package turf_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    localparam int ADDR_W       = 28;
    localparam int DATA_W       = 32;
    localparam int CRATE_ADDR_W = 27;
    localparam int NUM_LINKS    = 4;
    localparam int LINK_W       = $clog2(NUM_LINKS);
    localparam int REG_OFFSET_W = 4;

    typedef logic [ADDR_W-1:0]       addr_t;
    typedef logic [DATA_W-1:0]       data_t;
    typedef logic [CRATE_ADDR_W-1:0] crate_addr_t;
    typedef logic [LINK_W-1:0]       link_sel_t;
    typedef logic [NUM_LINKS-1:0]    link_mask_t;

    //////////////////////////////////////////////////////////////////////
    // ID space
    //////////////////////////////////////////////////////////////////////

    localparam logic [31:0] IDENT         = 32'h54555246;
    localparam logic        REVISION_B    = 1'b0;
    localparam logic [14:0] FIRMWARE_DATE = 15'h0000;
    localparam logic [3:0]  VER_MAJOR     = 4'd0;
    localparam logic [3:0]  VER_MINOR     = 4'd7;
    localparam logic [7:0]  VER_REV       = 8'd18;
    localparam logic [31:0] DATEVERSION   =
        {REVISION_B, FIRMWARE_DATE, VER_MAJOR, VER_MINOR, VER_REV};

    // Byte offsets inside the local space
    localparam logic [REG_OFFSET_W-1:0] REG_IDENT       = 4'h0;
    localparam logic [REG_OFFSET_W-1:0] REG_DATEVERSION = 4'h4;
    localparam logic [REG_OFFSET_W-1:0] REG_BRIDGE_CTRL = 4'h8;
    localparam logic [REG_OFFSET_W-1:0] REG_BRIDGE_STAT = 4'hC;

    //////////////////////////////////////////////////////////////////////
    // Crate bridge
    //////////////////////////////////////////////////////////////////////

    localparam int          BRIDGE_EN_BIT   = 8;
    localparam int          BRIDGE_TIMEOUT  = 64;
    localparam int          TIMEOUT_W       = $clog2(BRIDGE_TIMEOUT);
    localparam logic [TIMEOUT_W-1:0] TIMEOUT_LAST = TIMEOUT_W'(BRIDGE_TIMEOUT - 1);
    localparam logic [31:0] BRIDGE_ERR_DATA = 32'hBAD0BAD0;

    // Command toward a TURFIO link, 62 bits
    typedef struct packed {
        link_sel_t   link;
        logic        write;
        crate_addr_t addr;
        data_t       wdata;
    } crate_cmd_t;

    // Response back from the link, 33 bits
    typedef struct packed {
        data_t rdata;
        logic  err;
    } crate_resp_t;

endpackage

// ==== rtl/turf_stream_slice.sv ====
`timescale 1ns/10ps
module turf_stream_slice #(
    parameter type payload_t = logic
) (
    input  logic     ps_clk,
    input  logic     rst_i,
    input  logic     s_valid_i,
    output logic     s_ready_o,
    input  payload_t s_data_i,
    output logic     m_valid_o,
    input  logic     m_ready_i,
    output payload_t m_data_o
);

    logic     full_q;
    payload_t data_q;

    // Accept when empty or when the held item leaves this cycle
    assign s_ready_o = !full_q || m_ready_i;
    assign m_valid_o = full_q;
    assign m_data_o  = data_q;

    always_ff @(posedge ps_clk) begin
        if (rst_i) begin
            full_q <= 1'b0;
        end else if (s_valid_i && s_ready_o) begin
            full_q <= 1'b1;
        end else if (m_ready_i) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge ps_clk) begin
        if (s_valid_i && s_ready_o) begin
            data_q <= s_data_i;
        end
    end

endmodule

// ==== turf_ctrl.f ====
rtl/turf_pkg.sv
rtl/turf_stream_slice.sv
rtl/turf_apb_decode.sv
rtl/turf_id_regs.sv
rtl/turf_crate_bridge.sv
rtl/turf_ctrl_top.sv
verification/turf_ctrl_tb.sv

// ==== verification/turf_ctrl_tb.sv ====
`timescale 1ns/10ps
module turf_ctrl_tb;

    // Covers roughly 60 transfers that each end within the bridge timeout and APB overhead
    localparam int MAX_CYCLES = 20000;

    logic                  ps_clk;
    logic                  rst_i;
    logic                  psel_i;
    logic                  penable_i;
    logic                  pwrite_i;
    turf_pkg::addr_t       paddr_i;
    turf_pkg::data_t       pwdata_i;
    turf_pkg::data_t       prdata_o;
    logic                  pready_o;
    logic                  pslverr_o;
    turf_pkg::link_mask_t  link_up_i;
    logic                  cmd_valid_o;
    logic                  cmd_ready_i;
    turf_pkg::crate_cmd_t  cmd_data_o;
    logic                  resp_valid_i;
    logic                  resp_ready_o;
    turf_pkg::crate_resp_t resp_data_i;

    int                    check_count;
    int                    err_count;
    int                    cycles;
    string                 cur_test;
    logic                  muted;
    turf_pkg::link_sel_t   exp_link;
    // Link memories keyed by {link, crate address}
    turf_pkg::data_t       link_mem [logic [28:0]];
    turf_pkg::crate_cmd_t  seen_cmd;
    turf_pkg::crate_resp_t resp;
    logic [28:0]           mem_key;
    int unsigned           resp_delay;

    turf_ctrl_top DUT (.*);

    initial begin
        ps_clk = 1'b0;
        forever #10 ps_clk = ~ps_clk;
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge ps_clk);
            cycles = cycles + 1;
            if (cycles >= MAX_CYCLES) begin
                $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
                $display("Test failures found");
                $finish;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    task automatic check_data(input string name, input turf_pkg::data_t exp,
                              input turf_pkg::data_t act);
        check_count = check_count + 1;
        if (exp !== act) begin
            err_count = err_count + 1;
            $display("Mismatch in %s (%s): expected %h, actual %h",
                     cur_test, name, exp, act);
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        check_count = check_count + 1;
        if (exp !== act) begin
            err_count = err_count + 1;
            $display("Mismatch in %s (%s): expected %b, actual %b",
                     cur_test, name, exp, act);
        end
    endtask

    task automatic check_cmd_link(input string name, input turf_pkg::link_sel_t exp,
                                  input turf_pkg::link_sel_t act);
        check_count = check_count + 1;
        if (exp !== act) begin
            err_count = err_count + 1;
            $display("Mismatch in %s (%s): expected %0d, actual %0d",
                     cur_test, name, exp, act);
        end
    endtask

    task automatic report_test(input int errs_before);
        $display("Test %s: %s", cur_test, (err_count == errs_before) ? "PASS" : "FAIL");
    endtask

    // Status word holds live link-up above the sticky invalid and timeout flags
    function automatic turf_pkg::data_t status_word(input turf_pkg::link_mask_t up,
                                                    input turf_pkg::link_mask_t inv,
                                                    input turf_pkg::link_mask_t tmo);
        return {20'h0, up, inv, tmo};
    endfunction

    function automatic turf_pkg::addr_t crate_paddr(input turf_pkg::crate_addr_t a);
        return {1'b1, a};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // APB requester and link responder
    //////////////////////////////////////////////////////////////////////

    task automatic apb_xfer(input logic wr, input turf_pkg::addr_t addr,
                            input turf_pkg::data_t wdata,
                            output turf_pkg::data_t rdata, output logic err);
        @(posedge ps_clk);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= wr;
        paddr_i   <= addr;
        pwdata_i  <= wdata;
        @(posedge ps_clk);
        penable_i <= 1'b1;
        // Sample away from the clock edge
        do begin
            @(negedge ps_clk);
        end while (!pready_o);
        rdata = prdata_o;
        err   = pslverr_o;
        @(posedge ps_clk);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    // Random back-pressure on the command stream
    initial begin
        forever begin
            @(posedge ps_clk);
            cmd_ready_i <= ($urandom_range(0, 3) != 0);
        end
    end

    initial begin
        forever begin
            @(posedge ps_clk);
            if (!rst_i && cmd_valid_o && cmd_ready_i) begin
                seen_cmd = cmd_data_o;
                check_cmd_link("cmd link", exp_link, seen_cmd.link);
                mem_key = {seen_cmd.link, seen_cmd.addr};
                resp.err = 1'b0;
                resp.rdata = '0;
                if (seen_cmd.write) begin
                    link_mem[mem_key] = seen_cmd.wdata;
                end else if (link_mem.exists(mem_key)) begin
                    resp.rdata = link_mem[mem_key];
                end
                if (!muted) begin
                    resp_delay = $urandom_range(0, 10);
                    repeat (resp_delay) @(posedge ps_clk);
                    resp_valid_i <= 1'b1;
                    resp_data_i  <= resp;
                    do begin
                        @(posedge ps_clk);
                    end while (!resp_ready_o);
                    resp_valid_i <= 1'b0;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic read_id_space;
        int              errs0;
        turf_pkg::data_t rd;
        logic            err;
        cur_test = "local ID space";
        errs0 = err_count;
        apb_xfer(1'b0, 28'h0, '0, rd, err);
        check_data("ident", 32'h5455_5246, rd);
        check_err("ident", 1'b0, err);
        apb_xfer(1'b0, 28'h4, '0, rd, err);
        check_data("dateversion", 32'h0000_0712, rd);
        check_err("dateversion", 1'b0, err);
        apb_xfer(1'b0, 28'h100, '0, rd, err);
        check_data("unmapped", 32'h0, rd);
        check_err("unmapped", 1'b0, err);
        report_test(errs0);
    endtask

    task automatic ctrl_status_readback;
        int              errs0;
        turf_pkg::data_t rd;
        logic            err;
        cur_test = "control and status";
        errs0 = err_count;
        // Only the enable bit and the link number are kept
        apb_xfer(1'b1, 28'h8, 32'hFFFF_FFFF, rd, err);
        apb_xfer(1'b0, 28'h8, '0, rd, err);
        check_data("ctrl all ones", 32'h0000_0103, rd);
        apb_xfer(1'b1, 28'h8, 32'h0000_0102, rd, err);
        apb_xfer(1'b0, 28'h8, '0, rd, err);
        check_data("ctrl readback", 32'h0000_0102, rd);
        link_up_i <= 4'b1010;
        apb_xfer(1'b0, 28'hC, '0, rd, err);
        check_data("status links", status_word(4'b1010, 4'h0, 4'h0), rd);
        link_up_i <= 4'b0101;
        apb_xfer(1'b0, 28'hC, '0, rd, err);
        check_data("status links", status_word(4'b0101, 4'h0, 4'h0), rd);
        report_test(errs0);
    endtask

    task automatic bridge_round_trip;
        int                    errs0;
        turf_pkg::data_t       rd;
        logic                  err;
        turf_pkg::crate_addr_t addrs [4];
        turf_pkg::data_t       wdat [4];
        cur_test = "bridge write and read";
        errs0 = err_count;
        link_up_i <= 4'hF;
        for (int l = 0; l < 4; l++) begin
            exp_link = turf_pkg::link_sel_t'(l);
            apb_xfer(1'b1, 28'h8, 32'h0000_0100 | l, rd, err);
            for (int i = 0; i < 4; i++) begin
                addrs[i] = turf_pkg::crate_addr_t'($urandom());
                addrs[i][1:0] = 2'(i);
                wdat[i] = $urandom();
                apb_xfer(1'b1, crate_paddr(addrs[i]), wdat[i], rd, err);
                check_err("bridge write", 1'b0, err);
            end
            for (int i = 0; i < 4; i++) begin
                apb_xfer(1'b0, crate_paddr(addrs[i]), '0, rd, err);
                check_data("bridge read", wdat[i], rd);
                check_err("bridge read", 1'b0, err);
            end
        end
        report_test(errs0);
    endtask

    task automatic invalid_access_flags;
        int              errs0;
        turf_pkg::data_t rd;
        logic            err;
        cur_test = "invalid access";
        errs0 = err_count;
        // Link 2 is down while the bridge points at it
        link_up_i <= 4'b1011;
        apb_xfer(1'b1, 28'h8, 32'h0000_0102, rd, err);
        apb_xfer(1'b0, crate_paddr(27'h123), '0, rd, err);
        check_data("link down data", 32'hBAD0_BAD0, rd);
        check_err("link down err", 1'b1, err);
        apb_xfer(1'b0, 28'hC, '0, rd, err);
        check_data("invalid flag", status_word(4'b1011, 4'b0100, 4'h0), rd);
        apb_xfer(1'b1, 28'hC, 32'h0000_0040, rd, err);
        apb_xfer(1'b0, 28'hC, '0, rd, err);
        check_data("invalid clear", status_word(4'b1011, 4'h0, 4'h0), rd);
        // Bridge disabled on a live link
        apb_xfer(1'b1, 28'h8, 32'h0000_0001, rd, err);
        apb_xfer(1'b1, crate_paddr(27'h456), 32'h1234_5678, rd, err);
        check_data("disabled data", 32'hBAD0_BAD0, rd);
        check_err("disabled err", 1'b1, err);
        apb_xfer(1'b0, 28'hC, '0, rd, err);
        check_data("disabled flag", status_word(4'b1011, 4'b0010, 4'h0), rd);
        apb_xfer(1'b1, 28'hC, 32'h0000_0020, rd, err);
        apb_xfer(1'b0, 28'hC, '0, rd, err);
        check_data("disabled clear", status_word(4'b1011, 4'h0, 4'h0), rd);
        report_test(errs0);
    endtask

    task automatic bridge_timeout_recovery;
        int              errs0;
        turf_pkg::data_t rd;
        logic            err;
        cur_test = "bridge timeout";
        errs0 = err_count;
        link_up_i <= 4'hF;
        exp_link = 2'd1;
        apb_xfer(1'b1, 28'h8, 32'h0000_0101, rd, err);
        muted = 1'b1;
        apb_xfer(1'b0, crate_paddr(27'h777), '0, rd, err);
        check_data("timeout data", 32'hBAD0_BAD0, rd);
        check_err("timeout err", 1'b1, err);
        apb_xfer(1'b0, 28'hC, '0, rd, err);
        check_data("timeout flag", status_word(4'hF, 4'h0, 4'b0010), rd);
        muted = 1'b0;
        apb_xfer(1'b1, 28'hC, 32'h0000_0002, rd, err);
        apb_xfer(1'b1, crate_paddr(27'h777), 32'hCAFE_0001, rd, err);
        check_err("recovery write", 1'b0, err);
        apb_xfer(1'b0, crate_paddr(27'h777), '0, rd, err);
        check_data("recovery read", 32'hCAFE_0001, rd);
        check_err("recovery read", 1'b0, err);
        apb_xfer(1'b0, 28'hC, '0, rd, err);
        check_data("timeout clear", status_word(4'hF, 4'h0, 4'h0), rd);
        report_test(errs0);
    endtask

    initial begin
        rst_i        = 1'b1;
        psel_i       = 1'b0;
        penable_i    = 1'b0;
        pwrite_i     = 1'b0;
        paddr_i      = '0;
        pwdata_i     = '0;
        link_up_i    = '0;
        cmd_ready_i  = 1'b0;
        resp_valid_i = 1'b0;
        resp_data_i  = '0;
        muted        = 1'b0;
        exp_link     = '0;
        cur_test     = "reset";
        check_count  = 0;
        err_count    = 0;
        void'($urandom(32'h6416cf3a));
        repeat (2) @(posedge ps_clk);
        rst_i <= 1'b0;
        read_id_space();
        ctrl_status_readback();
        bridge_round_trip();
        invalid_access_flags();
        bridge_timeout_recovery();
        $display("Checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
